// File: filelist.f
source/iob_apb_pkg.sv
source/iob_bus_if.sv
source/apb_bus_if.sv
source/iob_iob2apb.sv
source/apb_reg_bank.sv
source/iob_apb_subsys.sv
verification/iob_apb_tb.sv

// File: Makefile
# Verilator build and run for the IOb to APB subsystem

TOP = iob_apb_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP)
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f filelist.f --top-module iob_apb_subsys

clean:
	rm -rf obj_dir

// File: verification/golden_vectors.txt
# op addr wdata wstrb expect bp (hex fields, bp 1 holds rready low through the read)
# Every word read before any write, then strobe, alias and back-pressure cases
R 00 00000000 0 00000000 0
R 04 00000000 0 00000000 0
R 08 00000000 0 00000000 0
R 0c 00000000 0 00000000 0
R 10 00000000 0 00000000 0
R 14 00000000 0 00000000 0
R 18 00000000 0 00000000 0
R 1c 00000000 0 00000000 0
R 20 00000000 0 00000000 0
R 24 00000000 0 00000000 0
R 28 00000000 0 00000000 0
R 2c 00000000 0 00000000 0
R 30 00000000 0 00000000 0
R 34 00000000 0 00000000 0
R 38 00000000 0 00000000 0
R 3c 00000000 0 00000000 0
W 00 11223344 f 00000000 0
W 04 a5a5a5a5 f 00000000 0
W 08 deadbeef f 00000000 0
W 0c 01234567 f 00000000 0
R 00 00000000 0 11223344 0
R 04 00000000 0 a5a5a5a5 0
R 08 00000000 0 deadbeef 0
R 0c 00000000 0 01234567 0
W 08 00000000 1 00000000 0
R 08 00000000 0 deadbe00 0
W 08 ffffffff 6 00000000 0
R 08 00000000 0 deffff00 0
W 08 12345678 8 00000000 0
R 08 00000000 0 12ffff00 0
W 0c 99887766 3 00000000 0
R 0c 00000000 0 01237766 0
W 0c aabbccdd 4 00000000 0
R 0c 00000000 0 01bb7766 0
W 10 cafef00d 5 00000000 0
R 10 00000000 0 00fe000d 0
W 10 55667788 a 00000000 0
R 10 00000000 0 55fe770d 0
W 14 0badf00d f 00000000 0
R 54 00000000 0 0badf00d 0
R 94 00000000 0 0badf00d 0
R d7 00000000 0 0badf00d 0
R 15 00000000 0 0badf00d 0
R 16 00000000 0 0badf00d 0
W bc 76543210 f 00000000 0
R 3c 00000000 0 76543210 0
R 7f 00000000 0 76543210 0
W 43 13572468 3 00000000 0
R 00 00000000 0 11222468 0
R c1 00000000 0 11222468 0
R 04 00000000 0 a5a5a5a5 0
R 08 00000000 0 12ffff00 1
R 08 00000000 0 12ffff00 0
W 18 fedcba98 f 00000000 0
R 0c 00000000 0 01bb7766 1
R 18 00000000 0 fedcba98 0
R 10 00000000 0 55fe770d 1
R 10 00000000 0 55fe770d 1
R 10 00000000 0 55fe770d 0
W 20 ffffffff f 00000000 0
W 20 00000000 9 00000000 0
R 20 00000000 0 00ffff00 0
R 1c 00000000 0 00000000 0

// File: verification/iob_apb_tb.sv
`timescale 1ns/1ps

module iob_apb_tb;
   import iob_apb_pkg::*;

   localparam int WAIT_STATES  = 2;   // Same as the bank inside the top level
   localparam int RESET_CYCLES = 10;
   localparam int MAX_GAP      = 3;
   localparam int TXN_WAIT_MAX = WAIT_STATES + 8;
   localparam int CLK_HALF     = 20;  // 40 ns period

   logic  clk_i;
   logic  rst_i;
   logic  iob_valid_i;
   addr_t iob_addr_i;
   data_t iob_wdata_i;
   strb_t iob_wstrb_i;
   logic  iob_rready_i;
   logic  iob_ready_o;
   logic  iob_rvalid_o;
   data_t iob_rdata_o;

   // Golden vectors with one entry per transaction
   bit    op_wr_q  [$];
   addr_t addr_q   [$];
   data_t wdata_q  [$];
   strb_t wstrb_q  [$];
   data_t expect_q [$];
   bit    bp_q     [$];  // Set means rready low through the read

   int          num_vec     = 0;
   int          err_cnt     = 0;
   int          pass_tests  = 0;
   int          fail_tests  = 0;
   int          cycle_cnt   = 0;
   int          cycle_limit = 0;
   logic        loaded      = 1'b0;
   logic [31:0] rnd;
   logic        held_known  = 1'b0;  // Held read response is a known golden word
   data_t       held_data   = '0;

   iob_apb_subsys dut_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .iob_valid_i  (iob_valid_i),
      .iob_addr_i   (iob_addr_i),
      .iob_wdata_i  (iob_wdata_i),
      .iob_wstrb_i  (iob_wstrb_i),
      .iob_rready_i (iob_rready_i),
      .iob_ready_o  (iob_ready_o),
      .iob_rvalid_o (iob_rvalid_o),
      .iob_rdata_o  (iob_rdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   // Linear congruential generator for idle gaps
   function automatic logic [31:0] next_random(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Error: time %0t, %s expected %b, got %b", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_word(input string name, input data_t got, input data_t exp);
      assert (got === exp) else begin
         $display("Error: time %0t, %s expected 0x%h, got 0x%h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_reset_outputs();
      check_bit("iob_ready_o", iob_ready_o, 1'b0);
      check_bit("iob_rvalid_o", iob_rvalid_o, 1'b0);
      check_word("iob_rdata_o", iob_rdata_o, '0);
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         pass_tests++;
         $display("%s: ok", name);
      end else begin
         fail_tests++;
         $display("%s: FAILED", name);
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    n;
      int    code;
      string line;
      string op_s;
      addr_t a;
      data_t wd;
      strb_t ws;
      data_t ex;
      int    bp;
      fd = $fopen("verification/golden_vectors.txt", "r");
      assert (fd != 0) else begin
         $display("Golden vector file could not be opened");
         err_cnt++;
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %h %h %h %d", op_s, a, wd, ws, ex, bp);
               if (n == 6) begin
                  assert (op_s == "W" || op_s == "R") else begin
                     $display("Unknown operation %s in golden file", op_s);
                     err_cnt++;
                  end
                  op_wr_q.push_back(op_s == "W");
                  addr_q.push_back(a);
                  wdata_q.push_back(wd);
                  wstrb_q.push_back(ws);
                  expect_q.push_back(ex);
                  bp_q.push_back(bp != 0);
               end
            end
         end
         $fclose(fd);
      end
      num_vec = op_wr_q.size();
   endtask

   // One IOb request where cycle 0 is the first cycle with valid high
   task automatic run_vector(input int idx, input logic next_rready);
      logic        is_wr;
      logic        rr;
      logic [1:0]  gap;
      int          cyc;
      is_wr = op_wr_q[idx];
      rr    = ~bp_q[idx];
      rnd   = next_random(rnd);
      gap   = rnd[17:16];
      repeat (gap) @(posedge clk_i);
      @(posedge clk_i);
      iob_valid_i <= 1'b1;
      iob_addr_i  <= addr_q[idx];
      iob_wdata_i <= wdata_q[idx];
      iob_wstrb_i <= is_wr ? wstrb_q[idx] : '0;
      @(negedge clk_i);
      cyc = 0;
      while (!iob_ready_o && cyc < TXN_WAIT_MAX) begin
         @(negedge clk_i);
         cyc++;
      end
      assert (iob_ready_o) else begin
         $display("Vector %0d: iob_ready_o never rose after the request", idx + 1);
         err_cnt++;
      end
      check_word("iob_ready_o latency", data_t'(cyc), data_t'(WAIT_STATES));
      @(posedge clk_i);
      iob_valid_i  <= 1'b0;
      iob_wstrb_i  <= '0;
      iob_rready_i <= next_rready;  // Already in place for the next request
      @(negedge clk_i);
      check_bit("iob_ready_o", iob_ready_o, 1'b0);  // Exactly one cycle
      if (is_wr && rr) begin
         check_bit("iob_rvalid_o", iob_rvalid_o, 1'b0);
      end else if (!is_wr && rr) begin
         check_bit("iob_rvalid_o", iob_rvalid_o, 1'b1);
         check_word("iob_rdata_o", iob_rdata_o, expect_q[idx]);
      end else if (!is_wr) begin
         // Stalled read must not disturb the response registers
         check_bit("iob_rvalid_o", iob_rvalid_o, held_known);
         if (held_known) begin
            check_word("iob_rdata_o", iob_rdata_o, held_data);
         end
      end
      if (!is_wr && rr && !next_rready) begin
         held_known = 1'b1;
         held_data  = expect_q[idx];
      end else if (rr || next_rready) begin
         held_known = 1'b0;
      end
      if (!is_wr && rr && next_rready) begin
         @(negedge clk_i);
         check_bit("iob_rvalid_o", iob_rvalid_o, 1'b0);  // Pulse is one cycle wide
      end
   endtask

   initial begin
      int   errs;
      logic next_rr;
      rst_i        = 1'b1;
      iob_valid_i  = 1'b0;
      iob_addr_i   = '0;
      iob_wdata_i  = '0;
      iob_wstrb_i  = '0;
      iob_rready_i = 1'b1;
      rnd          = 32'h3cbb_32d2;
      load_vectors();
      assert (num_vec > 0) else begin
         $display("No vectors found in the golden file");
         err_cnt++;
      end
      cycle_limit = RESET_CYCLES + num_vec * (WAIT_STATES + 3 + MAX_GAP) + 20;
      if (num_vec > 0) begin
         iob_rready_i = ~bp_q[0];
      end
      loaded = 1'b1;

      errs = err_cnt;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk_i);
         if (i == RESET_CYCLES - 1) begin
            rst_i <= 1'b0;
         end
         @(negedge clk_i);
         check_reset_outputs();
      end
      @(negedge clk_i);
      check_reset_outputs();  // First cycle out of reset
      report_test("reset", errs);

      for (int i = 0; i < num_vec; i++) begin
         errs    = err_cnt;
         next_rr = (i + 1 < num_vec) ? ~bp_q[i + 1] : 1'b1;
         run_vector(i, next_rr);
         report_test($sformatf("vector %0d %s 0x%h", i + 1,
                               op_wr_q[i] ? "write" : "read", addr_q[i]), errs);
      end

      $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
      if (fail_tests == 0 && err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog with a limit that follows from the vector count
   initial begin
      wait (loaded);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: source/iob_apb_subsys.sv
`timescale 1ns/1ps

module iob_apb_subsys (
   input  logic               clk_i,
   input  logic               rst_i,

   // CPU side IOb port
   input  logic               iob_valid_i,
   input  iob_apb_pkg::addr_t iob_addr_i,
   input  iob_apb_pkg::data_t iob_wdata_i,
   input  iob_apb_pkg::strb_t iob_wstrb_i,
   input  logic               iob_rready_i,
   output logic               iob_ready_o,
   output logic               iob_rvalid_o,
   output iob_apb_pkg::data_t iob_rdata_o
);

   iob_bus_if iob_bus ();
   apb_bus_if apb_bus ();

   // Requester side of the IOb group
   assign iob_bus.valid  = iob_valid_i;
   assign iob_bus.addr   = iob_addr_i;
   assign iob_bus.wdata  = iob_wdata_i;
   assign iob_bus.wstrb  = iob_wstrb_i;
   assign iob_bus.rready = iob_rready_i;

   // Responses back out to the CPU
   assign iob_ready_o  = iob_bus.ready;
   assign iob_rvalid_o = iob_bus.rvalid;
   assign iob_rdata_o  = iob_bus.rdata;

   iob_iob2apb bridge_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .iob   (iob_bus.slave),
      .apb   (apb_bus.master)
   );

   // Single APB slave, no decoder needed
   apb_reg_bank #(
      .WAIT_STATES (2)
   ) reg_bank_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .apb   (apb_bus.slave)
   );

endmodule

// File: source/apb_reg_bank.sv
`timescale 1ns/1ps

module apb_reg_bank #(
   parameter int unsigned WAIT_STATES = 2  // Cycles before ready
) (
   input logic      clk_i,
   input logic      rst_i,
   apb_bus_if.slave apb
);
   import iob_apb_pkg::*;

   data_t     regs [REG_NUM];
   wait_cnt_t wait_cnt;
   logic      access;     // Slave selected and enabled
   logic      last_wait;
   logic      xfer_done;
   reg_idx_t  idx;

   assign access    = apb.sel & apb.enable;
   assign last_wait = (wait_cnt == WAIT_CNT_W'(WAIT_STATES));
   assign xfer_done = access & last_wait;

   // Upper address bits and byte offset are ignored
   assign idx = apb.addr[IDX_LSB +: REG_IDX_W];

   // Counts enable cycles of the current transfer
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wait_cnt <= '0;
      end else if (!access) begin
         wait_cnt <= '0;
      end else if (last_wait) begin
         wait_cnt <= '0;  // Ready for a back-to-back transfer
      end else begin
         wait_cnt <= wait_cnt + WAIT_CNT_W'(1);
      end
   end

   assign apb.ready = xfer_done;

   // Byte-lane writes in the ready cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (xfer_done && apb.write) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (apb.wstrb[b]) begin
               regs[idx][b*BYTE_W +: BYTE_W] <= apb.wdata[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // Read data only during the ready cycle of a read
   always_comb begin
      apb.rdata = '0;
      if (xfer_done && !apb.write) begin
         apb.rdata = regs[idx];
      end
   end

endmodule

// File: source/iob_iob2apb.sv
`timescale 1ns/1ps

module iob_iob2apb (
   input logic       clk_i,
   input logic       rst_i,
   iob_bus_if.slave  iob,
   apb_bus_if.master apb
);
   import iob_apb_pkg::*;

   bridge_state_t state;
   bridge_state_t state_nxt;
   logic          apb_strobe;  // Shared sel and enable
   logic          is_write;
   logic          rvalid_nxt;
   data_t         rdata_q;
   logic          rvalid_q;

   assign is_write = |iob.wstrb;

   // Request fields go straight through to APB
   assign apb.addr   = iob.addr;
   assign apb.wdata  = iob.wdata;
   assign apb.wstrb  = iob.wstrb;
   assign apb.write  = is_write;

   // Strobe rises with valid when idle and holds through the transfer
   assign apb_strobe = (state == WAIT_READY) || (state == WAIT_VALID && iob.valid);

   // Select and enable move together without a setup phase
   assign apb.sel    = apb_strobe;
   assign apb.enable = apb_strobe;

   // Completion is reported in the same cycle as APB ready
   assign iob.ready  = apb.ready;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= WAIT_VALID;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;

      case (state)
         WAIT_VALID: begin
            if (iob.valid) begin
               // A zero-wait slave may answer right away
               if (apb.ready) begin
                  state_nxt = is_write ? WAIT_VALID : READ_DONE;
               end else begin
                  state_nxt = WAIT_READY;
               end
            end
         end

         WAIT_READY: begin
            if (apb.ready) begin
               // Writes skip the read idle cycle
               state_nxt = is_write ? WAIT_VALID : READ_DONE;
            end
         end

         READ_DONE: begin
            state_nxt = WAIT_VALID;  // Enable stays low here
         end

         default: begin
            state_nxt = WAIT_VALID;
         end
      endcase
   end

   // Only reads produce a response beat
   assign rvalid_nxt = apb.ready & ~is_write;

   // Read response held while the requester stalls
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdata_q  <= '0;
         rvalid_q <= 1'b0;
      end else if (iob.rready) begin
         rdata_q  <= apb.rdata;
         rvalid_q <= rvalid_nxt;
      end
   end

   assign iob.rdata  = rdata_q;
   assign iob.rvalid = rvalid_q;

endmodule

// File: source/apb_bus_if.sv
`timescale 1ns/1ps

interface apb_bus_if;
   import iob_apb_pkg::*;

   addr_t addr;
   logic  sel;
   logic  enable;
   logic  write;
   strb_t wstrb;
   data_t wdata;
   logic  ready;  // One cycle per transfer
   data_t rdata;  // Valid together with ready

   modport master (
      output addr,
      output sel,
      output enable,
      output write,
      output wstrb,
      output wdata,
      input  ready,
      input  rdata
   );

   modport slave (
      input  addr,
      input  sel,
      input  enable,
      input  write,
      input  wstrb,
      input  wdata,
      output ready,
      output rdata
   );

endinterface

// File: source/iob_bus_if.sv
`timescale 1ns/1ps

interface iob_bus_if;
   import iob_apb_pkg::*;

   // Request side
   logic  valid;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;   // Nonzero marks a write
   logic  rready;  // Requester can take read data

   // Response side
   logic  ready;
   logic  rvalid;
   data_t rdata;

   modport master (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      output rready,
      input  ready,
      input  rvalid,
      input  rdata
   );

   modport slave (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      input  rready,
      output ready,
      output rvalid,
      output rdata
   );

endinterface

// File: source/iob_apb_pkg.sv
package iob_apb_pkg;

   // Bus widths shared by IOb and APB
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;
   localparam int BYTE_W = 8;
   localparam int STRB_W = DATA_W / BYTE_W;

   // Register bank geometry
   localparam int REG_NUM   = 16;
   localparam int REG_IDX_W = 4;
   localparam int IDX_LSB   = 2;  // Word index starts above the byte offset

   // Wait-state counter, wide enough for any practical latency
   localparam int WAIT_CNT_W = 32;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [STRB_W-1:0]     strb_t;  // All zero means read
   typedef logic [REG_IDX_W-1:0]  reg_idx_t;
   typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

   // Bridge controller states
   typedef enum logic [1:0] {
      WAIT_VALID = 2'd0,  // Idle, waiting for an IOb request
      WAIT_READY = 2'd1,  // APB transfer in flight
      READ_DONE  = 2'd2   // One idle cycle after a read
   } bridge_state_t;

endpackage
